// File: design/alu.sv
`timescale 1ns/1ps

module alu import exe_pkg::*; (
	input  id_ex_t      ex,
	input  logic [31:0] hi,
	input  logic [31:0] lo,
	output logic [31:0] result,
	output logic        ovf,
	output logic        br_taken
);

	logic [31:0] num1;
	logic [31:0] num2;
	logic [31:0] imm_zext;
	logic [4:0]  shamt;
	logic [31:0] sum;
	logic [31:0] diff;
	logic        add_ovf;
	logic        sub_ovf;
	logic        diff_zero;

	assign num1 = ex.num1;
	assign num2 = ex.num2;

	// logic immediates only look at the low half of num2
	assign imm_zext = {16'h0000, num2[15:0]};

	// shift amount comes from rs
	assign shamt = num1[4:0];

	// shared adder and subtractor
	assign sum  = num1 + num2;
	assign diff = num1 - num2;

	// same-sign operands giving a result of the other sign
	assign add_ovf = (num1[31] == num2[31]) && (sum[31] != num1[31]);
	// operands of different sign, result sign not matching num1
	assign sub_ovf = (num1[31] != num2[31]) && (diff[31] != num1[31]);

	assign diff_zero = (diff == 32'h0000_0000);

	always_comb begin
		result = 32'h0000_0000;
		// hi/lo writers produce nothing on the result bus
		if (!is_muldiv(ex.op)) begin
			case (ex.op)
				// register logic
				op_and:   result = num1 & num2;
				op_or:    result = num1 | num2;
				op_xor:   result = num1 ^ num2;
				op_nor:   result = ~(num1 | num2);
				// logic immediates
				op_andi:  result = num1 & imm_zext;
				op_ori:   result = num1 | imm_zext;
				op_xori:  result = num1 ^ imm_zext;
				op_lui:   result = {num2[15:0], 16'h0000};
				// variable shifts of rt
				op_sllv:  result = num2 << shamt;
				op_srlv:  result = num2 >> shamt;
				op_srav:  result = $signed(num2) >>> shamt;
				// add/sub, trapping and not
				op_add,
				op_addu,
				op_addi,
				op_addiu: result = sum;
				op_sub,
				op_subu:  result = diff;
				// set on less than, signed and unsigned
				op_slt,
				op_slti:  result = {31'd0, $signed(num1) < $signed(num2)};
				op_sltu,
				op_sltiu: result = {31'd0, num1 < num2};
				// hi/lo reads
				op_mfhi:  result = hi;
				op_mflo:  result = lo;
				// jump target and memory addresses
				op_j,
				op_lb,
				op_lbu,
				op_lh,
				op_lhu,
				op_lw,
				op_sb,
				op_sh,
				op_sw:    result = sum;
				// branch compare value, zero means equal
				op_beq,
				op_bne:   result = diff;
				// cp0 write data passes through
				op_mtc0:  result = num2;
				op_eret:  result = 32'h0000_0000;
				default:  result = 32'h0000_0000;
			endcase
		end
	end

	// only the trapping forms flag overflow
	always_comb begin
		case (ex.op)
			op_add,
			op_addi: ovf = add_ovf;
			op_sub:  ovf = sub_ovf;
			default: ovf = 1'b0;
		endcase
	end

	// branch decision from the subtract result
	always_comb begin
		case (ex.op)
			op_beq:  br_taken = diff_zero;
			op_bne:  br_taken = !diff_zero;
			default: br_taken = 1'b0;
		endcase
	end

endmodule

// File: design/exe_pkg.sv
package exe_pkg;

	// execute operation codes, 8 bits like the decoder's control code
	// op_nop must stay at zero so an all-zero bundle is a bubble
	typedef enum logic [7:0] {
		op_nop = 8'h00,
		// register logic
		op_and,
		op_or,
		op_xor,
		op_nor,
		// logic immediates, zero-extended inside the alu
		op_andi,
		op_ori,
		op_xori,
		op_lui,
		// variable shifts
		op_sllv,
		op_srlv,
		op_srav,
		// arithmetic
		op_add,
		op_addu,
		op_sub,
		op_subu,
		op_addi,
		op_addiu,
		// set on less than
		op_slt,
		op_sltu,
		op_slti,
		op_sltiu,
		// hi/lo class
		op_mult,
		op_multu,
		op_div,
		op_divu,
		op_mfhi,
		op_mflo,
		op_mthi,
		op_mtlo,
		// control flow
		op_j,
		op_beq,
		op_bne,
		// memory access, address only
		op_lb,
		op_lbu,
		op_lh,
		op_lhu,
		op_lw,
		op_sb,
		op_sh,
		op_sw,
		// privileged
		op_mtc0,
		op_eret
	} alu_op_t;

	// decoded instruction entering execute
	typedef struct packed {
		logic        valid;
		alu_op_t     op;
		logic [31:0] num1;
		// sign/zero extended immediate already merged in where used
		logic [31:0] num2;
		logic        wreg;
		logic [4:0]  waddr;
	} id_ex_t;

	// execute result toward the memory stage
	typedef struct packed {
		logic        valid;
		alu_op_t     op;
		logic [31:0] result;
		// low whenever ovf is set
		logic        wreg;
		logic [4:0]  waddr;
		logic        ovf;
		logic        br_taken;
	} ex_mem_t;

	// ops handled by the multiply/divide unit instead of the alu datapath
	function automatic logic is_muldiv(alu_op_t op);
		return op inside {op_mult, op_multu, op_div, op_divu, op_mthi, op_mtlo};
	endfunction

endpackage

// File: design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import exe_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  id_ex_t  issue,
	input  logic    flush,
	output logic    stall,
	output ex_mem_t retire
);

	id_ex_t      ex_q;
	ex_mem_t     ex_mem_d;
	logic [31:0] alu_result;
	logic        alu_ovf;
	logic        alu_br_taken;
	logic [31:0] hi;
	logic [31:0] lo;
	logic        div_busy;

	// only the divider ever stalls the stage
	assign stall = div_busy;

	// id/ex, held under stall, flush drops the incoming bundle
	// or a divide already waiting here
	pipe_reg #(
		.payload_t (id_ex_t)
	) u_id_ex (
		.clk    (clk),
		.arst_n (arst_n),
		.hold   (stall),
		.clear  (flush),
		.d      (issue),
		.q      (ex_q)
	);

	alu u_alu (
		.ex       (ex_q),
		.hi       (hi),
		.lo       (lo),
		.result   (alu_result),
		.ovf      (alu_ovf),
		.br_taken (alu_br_taken)
	);

	muldiv_hilo u_muldiv (
		.clk    (clk),
		.arst_n (arst_n),
		.ex     (ex_q),
		.flush  (flush),
		.busy   (div_busy),
		.hi     (hi),
		.lo     (lo)
	);

	// next ex/mem bundle
	always_comb begin
		ex_mem_d.valid    = ex_q.valid;
		ex_mem_d.op       = ex_q.op;
		ex_mem_d.result   = alu_result;
		// overflow suppresses the register write
		ex_mem_d.wreg     = ex_q.wreg && !alu_ovf;
		ex_mem_d.waddr    = ex_q.waddr;
		ex_mem_d.ovf      = alu_ovf;
		ex_mem_d.br_taken = alu_br_taken;
	end

	// bubbles go downstream while the divider runs
	pipe_reg #(
		.payload_t (ex_mem_t)
	) u_ex_mem (
		.clk    (clk),
		.arst_n (arst_n),
		.hold   (1'b0),
		.clear  (stall),
		.d      (ex_mem_d),
		.q      (retire)
	);

endmodule

// File: design/muldiv_hilo.sv
`timescale 1ns/1ps

module muldiv_hilo import exe_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  id_ex_t      ex,
	input  logic        flush,
	output logic        busy,
	output logic [31:0] hi,
	output logic [31:0] lo
);

	logic        hilo_op;
	logic        is_signed;
	logic [32:0] mul_a;
	logic [32:0] mul_b;
	logic [65:0] product;
	logic        div_op;
	logic        div_start;
	logic [31:0] a_mag;
	logic [31:0] b_mag;
	logic        running;
	logic [4:0]  step_cnt;
	logic [31:0] rem_q;
	logic [31:0] quo_q;
	logic [31:0] dsr_q;
	logic        neg_quo;
	logic        neg_rem;
	logic [32:0] trial;
	logic [31:0] step_rem;
	logic [31:0] step_quo;
	logic        last_step;
	logic [31:0] quo_fix;
	logic [31:0] rem_fix;

	// valid hi/lo class op sitting in id/ex
	assign hilo_op   = ex.valid && is_muldiv(ex.op);
	assign is_signed = (ex.op == op_mult) || (ex.op == op_div);

	// one 33x33 signed multiplier covers both mult and multu
	assign mul_a   = {is_signed & ex.num1[31], ex.num1};
	assign mul_b   = {is_signed & ex.num2[31], ex.num2};
	assign product = $signed(mul_a) * $signed(mul_b);

	assign div_op    = hilo_op && ((ex.op == op_div) || (ex.op == op_divu));
	// idle divider picks up a new divide
	assign div_start = div_op && !running;

	// operand magnitudes for the unsigned core
	assign a_mag = (is_signed && ex.num1[31]) ? (~ex.num1 + 32'd1) : ex.num1;
	assign b_mag = (is_signed && ex.num2[31]) ? (~ex.num2 + 32'd1) : ex.num2;

	// one restoring step, next dividend bit shifted into the remainder
	assign trial = {rem_q, quo_q[31]} - {1'b0, dsr_q};

	always_comb begin
		if (trial[32]) begin
			// borrow, keep the shifted remainder
			step_rem = {rem_q[30:0], quo_q[31]};
			step_quo = {quo_q[30:0], 1'b0};
		end else begin
			step_rem = trial[31:0];
			step_quo = {quo_q[30:0], 1'b1};
		end
	end

	// the 32nd step is done combinationally and written straight to hi/lo
	assign last_step = running && (step_cnt == 5'd31);

	// sign fixup: quotient by operand signs, remainder follows dividend
	assign quo_fix = neg_quo ? (~step_quo + 32'd1) : step_quo;
	assign rem_fix = neg_rem ? (~step_rem + 32'd1) : step_rem;

	// high from the start cycle until the final step cycle
	assign busy = div_start || (running && (step_cnt != 5'd31));

	// divider sequencing
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			running  <= 1'b0;
			step_cnt <= 5'd0;
			rem_q    <= 32'd0;
			quo_q    <= 32'd0;
			dsr_q    <= 32'd0;
			neg_quo  <= 1'b0;
			neg_rem  <= 1'b0;
		end else if (flush) begin
			// cancel, hi/lo stay as they were
			running  <= 1'b0;
			step_cnt <= 5'd0;
		end else if (div_start) begin
			running  <= 1'b1;
			step_cnt <= 5'd0;
			rem_q    <= 32'd0;
			quo_q    <= a_mag;
			dsr_q    <= b_mag;
			neg_quo  <= is_signed && (ex.num1[31] ^ ex.num2[31]);
			neg_rem  <= is_signed && ex.num1[31];
		end else if (running) begin
			rem_q    <= step_rem;
			quo_q    <= step_quo;
			step_cnt <= step_cnt + 5'd1;
			if (last_step) begin
				running <= 1'b0;
			end
		end
	end

	// hi/lo update as the op leaves id/ex
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hi <= 32'd0;
			lo <= 32'd0;
		end else if (last_step && !flush) begin
			hi <= rem_fix;
			lo <= quo_fix;
		end else if (hilo_op) begin
			case (ex.op)
				op_mult,
				op_multu: begin
					hi <= product[63:32];
					lo <= product[31:0];
				end
				// mthi/mtlo take rs
				op_mthi:  hi <= ex.num1;
				op_mtlo:  lo <= ex.num1;
				default:  ;
			endcase
		end
	end

endmodule

// File: design/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	// bundle carried by this stage register
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     hold,
	input  logic     clear,
	input  payload_t d,
	output payload_t q
);

	// clear beats hold, an all-zero payload reads as a bubble
	// since its valid bit is low
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (clear) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

// File: sources.f
design/exe_pkg.sv
design/pipe_reg.sv
design/alu.sv
design/muldiv_hilo.sv
design/execute_stage.sv
testbench/execute_stage_chk.sv
testbench/execute_stage_tb.sv

// File: testbench/execute_stage_chk.sv
`timescale 1ns/1ps

module execute_stage_chk import exe_pkg::*; (
	input logic    clk,
	input logic    arst_n,
	input logic    flush,
	input logic    stall,
	input ex_mem_t retire
);

	// quiet outputs in reset and on the first edge out of it
	a_reset_quiet: assert property (
		@(posedge clk) (!arst_n || $rose(arst_n)) |-> (!retire.valid && !stall)
	) else $error("retire.valid or stall high around reset");

	// overflow never writes the register file
	a_ovf_no_write: assert property (
		@(posedge clk) disable iff (!arst_n) (retire.valid && retire.ovf) |-> !retire.wreg
	) else $error("retired instruction with ovf set still has wreg");

	// a stalled cycle sends a bubble to ex/mem
	a_stall_bubble: assert property (
		@(posedge clk) disable iff (!arst_n) $past(stall) |-> !retire.valid
	) else $error("valid instruction retired behind a stall");

	// divider holds the stage 32 cycles, one spare
	a_stall_bound: assert property (
		@(posedge clk) disable iff (!arst_n) $rose(stall) |-> ##[1:33] !stall
	) else $error("stall held longer than 33 cycles");

	// flush kills a running divide
	a_flush_clears_stall: assert property (
		@(posedge clk) disable iff (!arst_n) flush |=> !stall
	) else $error("stall still high the cycle after flush");

endmodule

bind execute_stage execute_stage_chk u_chk (
	.clk    (clk),
	.arst_n (arst_n),
	.flush  (flush),
	.stall  (stall),
	.retire (retire)
);

// File: testbench/execute_stage_tb.sv
`timescale 1ns/1ps

module execute_stage_tb import exe_pkg::*; ();

	// six tests run in roughly 250 cycles, the divides about 35 each
	// so 2000 leaves a wide margin
	localparam int max_cycles = 2000;

	logic        clk;
	logic        arst_n;
	logic        flush;
	id_ex_t      issue;
	logic        stall;
	ex_mem_t     retire;
	integer      seed;
	int          cycle = 0;
	int          check_errs;
	int          other_errs;
	int          last_hold;
	logic [31:0] model_hi;
	logic [31:0] model_lo;
	// expected retire bundles and the cycle each one is due
	ex_mem_t     exp_q[$];
	int          due_q[$];

	execute_stage u_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.issue  (issue),
		.flush  (flush),
		.stall  (stall),
		.retire (retire)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// watchdog
	initial begin
		wait (cycle >= max_cycles);
		$display("timeout: run stopped after %0d cycles", cycle);
		$display("FAIL: see errors above");
		$finish;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			check_errs++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	// expected ex/mem bundle, straight from the isa rules
	function automatic ex_mem_t predict(input id_ex_t in);
		ex_mem_t     e;
		logic [32:0] wide;
		logic [31:0] a;
		logic [31:0] b;
		a = in.num1;
		b = in.num2;
		e = '0;
		e.valid = 1'b1;
		e.op = in.op;
		e.waddr = in.waddr;
		case (in.op)
			op_and:  e.result = a & b;
			op_or:   e.result = a | b;
			op_xor:  e.result = a ^ b;
			op_nor:  e.result = ~(a | b);
			// logic immediates see only the low half
			op_andi: e.result = a & {16'h0000, b[15:0]};
			op_ori:  e.result = a | {16'h0000, b[15:0]};
			op_xori: e.result = a ^ {16'h0000, b[15:0]};
			op_lui:  e.result = b << 16;
			op_sllv: e.result = b << a[4:0];
			op_srlv: e.result = b >> a[4:0];
			op_srav: e.result = $signed(b) >>> a[4:0];
			// 33-bit sign-extended sum, top two bits differ on overflow
			op_add,
			op_addi: begin
				wide = {a[31], a} + {b[31], b};
				e.result = wide[31:0];
				e.ovf = wide[32] ^ wide[31];
			end
			op_sub: begin
				wide = {a[31], a} - {b[31], b};
				e.result = wide[31:0];
				e.ovf = wide[32] ^ wide[31];
			end
			op_subu: e.result = a - b;
			op_slt,
			op_slti: e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			op_sltu,
			op_sltiu: e.result = (a < b) ? 32'd1 : 32'd0;
			op_addu, op_addiu, op_j,
			op_lb, op_lbu, op_lh, op_lhu, op_lw,
			op_sb, op_sh, op_sw: e.result = a + b;
			op_mfhi: e.result = model_hi;
			op_mflo: e.result = model_lo;
			op_beq:  e.br_taken = (a == b);
			op_bne:  e.br_taken = (a != b);
			op_mtc0: e.result = b;
			// eret, nop and the hi/lo writers
			default: e.result = 32'h0000_0000;
		endcase
		e.wreg = in.wreg && !e.ovf;
		return e;
	endfunction

	function automatic void update_hilo(input id_ex_t in);
		logic [63:0] prod;
		case (in.op)
			op_mult: begin
				prod = {{32{in.num1[31]}}, in.num1} * {{32{in.num2[31]}}, in.num2};
				model_hi = prod[63:32];
				model_lo = prod[31:0];
			end
			op_multu: begin
				prod = {32'h0, in.num1} * {32'h0, in.num2};
				model_hi = prod[63:32];
				model_lo = prod[31:0];
			end
			// truncating quotient, remainder keeps the dividend sign
			op_div: begin
				model_lo = $signed(in.num1) / $signed(in.num2);
				model_hi = $signed(in.num1) % $signed(in.num2);
			end
			op_divu: begin
				model_lo = in.num1 / in.num2;
				model_hi = in.num1 % in.num2;
			end
			op_mthi: model_hi = in.num1;
			op_mtlo: model_lo = in.num1;
			default: ;
		endcase
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// drive one bundle, hold it through stall, then return to a bubble
	task automatic send(input alu_op_t op, input logic [31:0] a, input logic [31:0] b,
			input logic tracked, input logic with_flush);
		id_ex_t      in;
		logic        held;
		logic [31:0] r;
		r = rand_word();
		in.valid = 1'b1;
		in.op = op;
		in.num1 = a;
		in.num2 = b;
		in.wreg = 1'b1;
		// random destination register
		in.waddr = r[4:0];
		issue = in;
		flush = with_flush;
		last_hold = 0;
		do begin
			@(negedge clk);
			held = stall;
			@(posedge clk);
			if (held) begin
				last_hold++;
			end
		end while (held);
		#1;
		issue = '0;
		flush = 1'b0;
		if (tracked) begin
			exp_q.push_back(predict(in));
			// divide waits out 32 stall cycles plus its final cycle
			due_q.push_back(cycle + ((op == op_div || op == op_divu) ? 33 : 1));
			update_hilo(in);
		end
	endtask

	// retire monitor, mid-cycle sampling
	always @(negedge clk) begin
		ex_mem_t e;
		int      due;
		if (arst_n && retire.valid) begin
			if (exp_q.size() == 0) begin
				other_errs++;
				$display("an instruction retired that was not expected, cycle %0d", cycle);
			end else begin
				e = exp_q.pop_front();
				due = due_q.pop_front();
				check("retire cycle", cycle, due);
				check("retire.op", retire.op, e.op);
				// branch result bus carries no defined value
				if (e.op != op_beq && e.op != op_bne) begin
					check("retire.result", retire.result, e.result);
				end
				check("retire.ovf", retire.ovf, e.ovf);
				check("retire.wreg", retire.wreg, e.wreg);
				check("retire.waddr", retire.waddr, e.waddr);
				check("retire.br_taken", retire.br_taken, e.br_taken);
			end
		end
	end

	task automatic test_logic();
		alu_op_t ops[11] = '{op_and, op_or, op_xor, op_nor, op_andi, op_ori,
			op_xori, op_lui, op_sllv, op_srlv, op_srav};
		foreach (ops[i]) begin
			send(ops[i], rand_word(), rand_word(), 1'b1, 1'b0);
		end
	endtask

	task automatic test_arith();
		alu_op_t ops[10] = '{op_add, op_addu, op_sub, op_subu, op_addi,
			op_addiu, op_slt, op_sltu, op_slti, op_sltiu};
		alu_op_t mem_ops[9] = '{op_lb, op_lbu, op_lh, op_lhu, op_lw,
			op_sb, op_sh, op_sw, op_j};
		foreach (ops[i]) begin
			send(ops[i], rand_word(), rand_word(), 1'b1, 1'b0);
		end
		// overflow corners, trapping and non-trapping forms
		send(op_add, 32'h7fff_ffff, 32'h0000_0001, 1'b1, 1'b0);
		send(op_addu, 32'h7fff_ffff, 32'h0000_0001, 1'b1, 1'b0);
		send(op_addi, 32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b0);
		send(op_sub, 32'h8000_0000, 32'h0000_0001, 1'b1, 1'b0);
		send(op_subu, 32'h8000_0000, 32'h0000_0001, 1'b1, 1'b0);
		// -1 against 1, signed and unsigned disagree
		send(op_slt, 32'hffff_ffff, 32'h0000_0001, 1'b1, 1'b0);
		send(op_sltu, 32'hffff_ffff, 32'h0000_0001, 1'b1, 1'b0);
		foreach (mem_ops[i]) begin
			send(mem_ops[i], rand_word(), rand_word(), 1'b1, 1'b0);
		end
	endtask

	task automatic test_mult();
		repeat (3) begin
			send(op_mult, rand_word(), rand_word(), 1'b1, 1'b0);
			send(op_mfhi, 32'h0, 32'h0, 1'b1, 1'b0);
			send(op_mflo, 32'h0, 32'h0, 1'b1, 1'b0);
			send(op_multu, rand_word(), rand_word(), 1'b1, 1'b0);
			send(op_mfhi, 32'h0, 32'h0, 1'b1, 1'b0);
			send(op_mflo, 32'h0, 32'h0, 1'b1, 1'b0);
		end
	endtask

	task automatic test_divide();
		alu_op_t     ops[3] = '{op_div, op_div, op_divu};
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		foreach (ops[i]) begin
			a = rand_word();
			r = rand_word();
			// 16-bit divisor keeps the quotient interesting
			b = (ops[i] == op_div) ? {{16{r[15]}}, r[15:0]} : {16'h0000, r[15:0]};
			if (i == 0) begin
				a = 32'hffff_fff9;
				b = 32'h0000_0002;
			end
			if (b == 32'h0 || b == 32'hffff_ffff) begin
				b = 32'd3;
			end
			send(ops[i], a, b, 1'b1, 1'b0);
			send(op_mflo, 32'h0, 32'h0, 1'b1, 1'b0);
			check("stall cycles", last_hold, 32);
			send(op_mfhi, 32'h0, 32'h0, 1'b1, 1'b0);
		end
	endtask

	task automatic test_branch_sys();
		logic [31:0] a;
		a = rand_word();
		send(op_beq, a, a, 1'b1, 1'b0);
		send(op_beq, a, a ^ 32'h0000_0010, 1'b1, 1'b0);
		send(op_bne, a, a, 1'b1, 1'b0);
		send(op_bne, a, ~a, 1'b1, 1'b0);
		send(op_mthi, rand_word(), 32'h0, 1'b1, 1'b0);
		send(op_mtlo, rand_word(), 32'h0, 1'b1, 1'b0);
		send(op_mfhi, 32'h0, 32'h0, 1'b1, 1'b0);
		send(op_mflo, 32'h0, 32'h0, 1'b1, 1'b0);
		send(op_mtc0, rand_word(), rand_word(), 1'b1, 1'b0);
		send(op_eret, rand_word(), rand_word(), 1'b1, 1'b0);
	endtask

	task automatic test_flush();
		// dropped on its way into id/ex, the monitor flags it if it shows up
		send(op_add, rand_word(), rand_word(), 1'b0, 1'b1);
		repeat (3) step();
		send(op_mthi, rand_word(), 32'h0, 1'b1, 1'b0);
		send(op_mtlo, rand_word(), 32'h0, 1'b1, 1'b0);
		// cancelled divide, hi/lo model left alone
		send(op_div, rand_word(), 32'd5, 1'b0, 1'b0);
		repeat (4) step();
		@(negedge clk);
		check("stall", stall, 1'b1);
		step();
		flush = 1'b1;
		step();
		flush = 1'b0;
		@(negedge clk);
		check("stall", stall, 1'b0);
		step();
		send(op_mfhi, 32'h0, 32'h0, 1'b1, 1'b0);
		send(op_mflo, 32'h0, 32'h0, 1'b1, 1'b0);
	endtask

	initial begin
		seed = 32'hc0ca5f5f;
		arst_n = 1'b0;
		flush = 1'b0;
		issue = '0;
		check_errs = 0;
		other_errs = 0;
		model_hi = 32'h0;
		model_lo = 32'h0;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		step();
		test_logic();
		test_arith();
		test_mult();
		test_divide();
		test_branch_sys();
		test_flush();
		// let the pipe drain
		while (exp_q.size() != 0) begin
			step();
		end
		repeat (2) step();
		$display("errors: %0d value mismatches, %0d other failures", check_errs, other_errs);
		if (check_errs == 0 && other_errs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
